// File: hdl/ex_pkg.sv
// Execute stage package with widths, operator encoding, instruction,
// write-back and branch resolution types

package ex_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    // --------------------------------------------------
    // Operator encoding
    // --------------------------------------------------
    typedef enum logic [4:0] {
        // Arithmetic, logic, shift and set-less-than
        ADD, SUB, AND_OP, OR_OP, XOR_OP, SLL, SRL, SRA, SLTS, SLTU,
        // Conditional branches and indirect jump
        EQ, NE, LTS, GES, LTU, GEU, JALR,
        // CSR access
        CSR_RW,
        // Multiply
        MUL, MULH, MULHU
    } fu_op_e;

    // CSR address sits in the low bits of operand b
    typedef struct packed {
        logic [XLEN-CSR_ADDR_BITS-1:0] unused;
        logic [CSR_ADDR_BITS-1:0]      addr;
    } csr_view_t;

    typedef union packed {
        logic [XLEN-1:0] data;
        csr_view_t       csr;
    } operand_b_u;

    // Issued instruction
    typedef struct packed {
        fu_op_e                   operator;
        logic [XLEN-1:0]          operand_a;
        operand_b_u               operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // --------------------------------------------------
    // Branch prediction and resolution
    // --------------------------------------------------
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_predict_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target_address;
        logic            is_mispredict;
        logic            is_taken;
    } bp_resolve_t;

    // --------------------------------------------------
    // Scoreboard write-back
    // --------------------------------------------------
    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
    } flu_wb_t;

endpackage

// File: hdl/alu.sv
// Combinational ALU for arithmetic, logic, shift and compare operations
// with branch comparison output
`timescale 1ns/1ns

module alu (
    input  ex_pkg::fu_data_t        fu_data_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    branch_res_o
);

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic                    is_equal;
    logic                    less_signed;
    logic                    less_unsigned;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b.data;
    assign shamt = op_b[4:0];

    // --------------------------------------------------
    // Comparisons
    // --------------------------------------------------
    assign is_equal      = (op_a == op_b);
    assign less_signed   = ($signed(op_a) < $signed(op_b));
    assign less_unsigned = (op_a < op_b);

    // Branch outcome for the six conditional branches
    always_comb begin
        case (fu_data_i.operator)
            ex_pkg::EQ:  branch_res_o = is_equal;
            ex_pkg::NE:  branch_res_o = ~is_equal;
            ex_pkg::LTS: branch_res_o = less_signed;
            ex_pkg::GES: branch_res_o = ~less_signed;
            ex_pkg::LTU: branch_res_o = less_unsigned;
            ex_pkg::GEU: branch_res_o = ~less_unsigned;
            default:     branch_res_o = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Result
    // --------------------------------------------------
    always_comb begin
        case (fu_data_i.operator)
            ex_pkg::ADD: begin
                result_o = op_a + op_b;
            end
            ex_pkg::SUB: begin
                result_o = op_a - op_b;
            end
            ex_pkg::AND_OP: begin
                result_o = op_a & op_b;
            end
            ex_pkg::OR_OP: begin
                result_o = op_a | op_b;
            end
            ex_pkg::XOR_OP: begin
                result_o = op_a ^ op_b;
            end
            ex_pkg::SLL: begin
                result_o = op_a << shamt;
            end
            ex_pkg::SRL: begin
                result_o = op_a >> shamt;
            end
            ex_pkg::SRA: begin
                // Arithmetic shift keeps the sign
                result_o = $unsigned($signed(op_a) >>> shamt);
            end
            ex_pkg::SLTS: begin
                result_o = {{(ex_pkg::XLEN-1){1'b0}}, less_signed};
            end
            ex_pkg::SLTU: begin
                result_o = {{(ex_pkg::XLEN-1){1'b0}}, less_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: hdl/branch_unit.sv
// Branch unit with target computation, link address and mispredict check
`timescale 1ns/1ns

module branch_unit (
    input  ex_pkg::fu_data_t        fu_data_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic                    is_compressed_instr_i,
    input  logic                    branch_valid_i,
    input  logic                    branch_comp_res_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output logic [ex_pkg::XLEN-1:0] branch_result_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o
);

    logic                    is_jalr;
    logic [ex_pkg::XLEN-1:0] target_base;
    logic [ex_pkg::XLEN-1:0] target_sum;
    logic [ex_pkg::XLEN-1:0] target;
    logic                    taken;
    logic                    target_differs;

    assign is_jalr = (fu_data_i.operator == ex_pkg::JALR);

    // --------------------------------------------------
    // Target address
    // --------------------------------------------------
    // JALR jumps relative to rs1, branches relative to pc
    assign target_base = is_jalr ? fu_data_i.operand_a : pc_i;
    assign target_sum  = target_base + fu_data_i.imm;

    // Bit 0 is cleared only for JALR
    assign target = {target_sum[ex_pkg::XLEN-1:1], target_sum[0] & ~is_jalr};

    assign taken = is_jalr | branch_comp_res_i;

    // Link address of the next sequential instruction
    assign branch_result_o = pc_i + (is_compressed_instr_i ? 32'd2 : 32'd4);

    // --------------------------------------------------
    // Resolution towards the frontend
    // --------------------------------------------------
    assign target_differs = (target != branch_predict_i.target);

    always_comb begin
        resolved_branch_o.valid          = branch_valid_i;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.target_address = target;
        resolved_branch_o.is_taken       = taken;
        // Wrong direction, or right direction with the wrong target
        resolved_branch_o.is_mispredict  = (taken != branch_predict_i.taken)
                                         | (taken & branch_predict_i.taken & target_differs);
    end

endmodule

// File: hdl/csr_buffer.sv
// One-entry buffer for the address of a pending CSR access
`timescale 1ns/1ns

module csr_buffer (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  logic                             csr_valid_i,
    input  logic                             csr_commit_i,
    output logic                             csr_ready_o,
    output logic [ex_pkg::XLEN-1:0]          csr_result_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                             full_q;
    logic [ex_pkg::CSR_ADDR_BITS-1:0] addr_q;

    // Entry stays occupied until the access commits or is flushed
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (csr_commit_i || flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= fu_data_i.operand_b.csr.addr;
        end
    end

    assign csr_ready_o  = ~full_q;
    assign csr_addr_o   = addr_q;
    // Write data goes back to the scoreboard unchanged
    assign csr_result_o = fu_data_i.operand_a;

endmodule

// File: hdl/mult.sv
// Single-cycle-latency multiplier for MUL, MULH and MULHU
`timescale 1ns/1ns

module mult (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             mult_valid_i,
    input  ex_pkg::fu_data_t fu_data_i,
    output ex_pkg::flu_wb_t  mult_wb_o
);

    logic signed [2*ex_pkg::XLEN-1:0] product_signed;
    logic        [2*ex_pkg::XLEN-1:0] product_unsigned;
    logic        [ex_pkg::XLEN-1:0]   result_d;

    logic                             valid_q;
    logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_q;
    logic [ex_pkg::XLEN-1:0]          result_q;

    // --------------------------------------------------
    // Products
    // --------------------------------------------------
    assign product_signed = $signed({{ex_pkg::XLEN{fu_data_i.operand_a[ex_pkg::XLEN-1]}},
                                     fu_data_i.operand_a})
                          * $signed({{ex_pkg::XLEN{fu_data_i.operand_b.data[ex_pkg::XLEN-1]}},
                                     fu_data_i.operand_b.data});
    assign product_unsigned = {{ex_pkg::XLEN{1'b0}}, fu_data_i.operand_a}
                            * {{ex_pkg::XLEN{1'b0}}, fu_data_i.operand_b.data};

    // Low half is the same for signed and unsigned
    always_comb begin
        case (fu_data_i.operator)
            ex_pkg::MULH:  result_d = product_signed[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::MULHU: result_d = product_unsigned[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            default:       result_d = product_unsigned[ex_pkg::XLEN-1:0];
        endcase
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            trans_id_q <= fu_data_i.trans_id;
            result_q   <= result_d;
        end
    end

    assign mult_wb_o = '{valid: valid_q, trans_id: trans_id_q, result: result_q};

endmodule

// File: hdl/flu_wb_arbiter.sv
// Fixed-priority arbiter for the shared fixed-latency write-back port
`timescale 1ns/1ns

module flu_wb_arbiter (
    input  logic                             alu_valid_i,
    input  logic                             branch_valid_i,
    input  logic                             csr_valid_i,
    input  logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [ex_pkg::XLEN-1:0]          alu_result_i,
    input  logic [ex_pkg::XLEN-1:0]          branch_result_i,
    input  logic [ex_pkg::XLEN-1:0]          csr_result_i,
    input  ex_pkg::flu_wb_t                  mult_wb_i,
    output ex_pkg::flu_wb_t                  flu_wb_o
);

    logic comb_valid;

    // Sources that write back in their issue cycle
    assign comb_valid = alu_valid_i | branch_valid_i | csr_valid_i;

    always_comb begin
        flu_wb_o.valid = comb_valid | mult_wb_i.valid;

        // Registered multiply id unless a same-cycle source is granted
        flu_wb_o.trans_id = comb_valid ? trans_id_i : mult_wb_i.trans_id;

        // ALU > branch > CSR > multiplier
        if (alu_valid_i) begin
            flu_wb_o.result = alu_result_i;
        end else if (branch_valid_i) begin
            flu_wb_o.result = branch_result_i;
        end else if (csr_valid_i) begin
            flu_wb_o.result = csr_result_i;
        end else begin
            flu_wb_o.result = mult_wb_i.result;
        end
    end

endmodule

// File: hdl/ex_stage.sv
// Execute stage top with ALU, branch unit, CSR buffer, multiplier and
// the write-back arbiter
`timescale 1ns/1ns

module ex_stage (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_data_t                 fu_data_i,
    input  logic [ex_pkg::XLEN-1:0]          pc_i,
    input  logic                             is_compressed_instr_i,
    input  logic                             alu_valid_i,
    input  logic                             branch_valid_i,
    input  logic                             csr_valid_i,
    input  logic                             mult_valid_i,
    input  ex_pkg::branch_predict_t          branch_predict_i,
    input  logic                             csr_commit_i,
    output ex_pkg::flu_wb_t                  flu_wb_o,
    output logic                             flu_ready_o,
    output ex_pkg::bp_resolve_t              resolved_branch_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic [ex_pkg::XLEN-1:0] alu_result;
    logic                    alu_branch_res;
    logic [ex_pkg::XLEN-1:0] branch_result;
    logic [ex_pkg::XLEN-1:0] csr_result;
    ex_pkg::flu_wb_t         mult_wb;

    // --------------------------------------------------
    // Single-cycle units
    // --------------------------------------------------
    alu i_alu (
        .fu_data_i    ( fu_data_i      ),
        .result_o     ( alu_result     ),
        .branch_res_o ( alu_branch_res )
    );

    branch_unit i_branch_unit (
        .fu_data_i,
        .pc_i,
        .is_compressed_instr_i,
        .branch_valid_i,
        .branch_comp_res_i ( alu_branch_res    ),
        .branch_predict_i,
        .branch_result_o   ( branch_result     ),
        .resolved_branch_o ( resolved_branch_o )
    );

    // Full CSR buffer is the only source of back-pressure
    csr_buffer i_csr_buffer (
        .clk_i,
        .rst_ni,
        .flush_i,
        .fu_data_i,
        .csr_valid_i,
        .csr_commit_i,
        .csr_ready_o  ( flu_ready_o ),
        .csr_result_o ( csr_result  ),
        .csr_addr_o   ( csr_addr_o  )
    );

    // --------------------------------------------------
    // Registered multiplier and shared port
    // --------------------------------------------------
    mult i_mult (
        .clk_i,
        .rst_ni,
        .flush_i,
        .mult_valid_i,
        .fu_data_i,
        .mult_wb_o ( mult_wb )
    );

    flu_wb_arbiter i_flu_wb_arbiter (
        .alu_valid_i,
        .branch_valid_i,
        .csr_valid_i,
        .trans_id_i      ( fu_data_i.trans_id ),
        .alu_result_i    ( alu_result         ),
        .branch_result_i ( branch_result      ),
        .csr_result_i    ( csr_result         ),
        .mult_wb_i       ( mult_wb            ),
        .flu_wb_o        ( flu_wb_o           )
    );

endmodule

// File: include/ex_model.svh
// Reference model functions for ALU, branch and multiply results
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// ALU result and branch comparison outcome
function automatic logic [31:0] model_alu(input ex_pkg::fu_data_t d);
    logic [31:0] a;
    logic [31:0] b;
    a = d.operand_a;
    b = d.operand_b.data;
    case (d.operator)
        ex_pkg::ADD:    return a + b;
        ex_pkg::SUB:    return a - b;
        ex_pkg::AND_OP: return a & b;
        ex_pkg::OR_OP:  return a | b;
        ex_pkg::XOR_OP: return a ^ b;
        ex_pkg::SLL:    return a << b[4:0];
        ex_pkg::SRL:    return a >> b[4:0];
        ex_pkg::SRA:    return $unsigned($signed(a) >>> b[4:0]);
        ex_pkg::SLTS:   return {31'b0, $signed(a) < $signed(b)};
        ex_pkg::SLTU:   return {31'b0, a < b};
        default:        return 32'b0;
    endcase
endfunction

function automatic logic model_taken(input ex_pkg::fu_data_t d);
    logic [31:0] a;
    logic [31:0] b;
    a = d.operand_a;
    b = d.operand_b.data;
    case (d.operator)
        ex_pkg::EQ:   return a == b;
        ex_pkg::NE:   return a != b;
        ex_pkg::LTS:  return $signed(a) < $signed(b);
        ex_pkg::GES:  return $signed(a) >= $signed(b);
        ex_pkg::LTU:  return a < b;
        ex_pkg::GEU:  return a >= b;
        ex_pkg::JALR: return 1'b1;
        default:      return 1'b0;
    endcase
endfunction

function automatic logic [31:0] model_target(input ex_pkg::fu_data_t d, input logic [31:0] pc);
    if (d.operator == ex_pkg::JALR) begin
        return (d.operand_a + d.imm) & 32'hffff_fffe;
    end
    return pc + d.imm;
endfunction

// Upper and lower product halves via 64-bit arithmetic
function automatic logic [31:0] model_mult(input ex_pkg::fu_data_t d);
    logic signed [63:0] ps;
    logic [63:0] pu;
    ps = 64'($signed(d.operand_a)) * 64'($signed(d.operand_b.data));
    pu = 64'(d.operand_a) * 64'(d.operand_b.data);
    if (d.operator == ex_pkg::MULH) return ps[63:32];
    if (d.operator == ex_pkg::MULHU) return pu[63:32];
    return pu[31:0];
endfunction

`endif

// File: verif/ex_stage_tb.sv
// Testbench for the execute stage with random ALU, branch, CSR and
// multiply traffic checked against a reference model
`timescale 1ns/1ns

module ex_stage_tb;

    localparam int N_ALU      = 200;
    localparam int N_BRANCH   = 200;
    localparam int N_CSR      = 40;
    localparam int N_MULT     = 200;
    localparam int N_MIXED    = 400;
    localparam int TOTAL_OPS  = N_ALU + N_BRANCH + N_CSR + N_MULT + N_MIXED;
    localparam int TIMEOUT_NS = (TOTAL_OPS * 3 + 20) * 40;

    // Everything driven into the DUT in one cycle
    typedef struct packed {
        ex_pkg::fu_data_t        data;
        logic [31:0]             pc;
        logic                    compressed;
        logic                    alu;
        logic                    branch;
        logic                    csr;
        logic                    mult;
        ex_pkg::branch_predict_t pred;
        logic                    commit;
        logic                    flush;
    } stim_t;

    logic                clk = 1'b0;
    logic                rst_n;
    stim_t               cur;
    stim_t               nxt;
    ex_pkg::flu_wb_t     flu_wb;
    logic                flu_ready;
    ex_pkg::bp_resolve_t resolved;
    logic [11:0]         csr_addr;
    integer              seed = 32'he5bcc838;

    // Model state as seen during the next driven cycle
    logic        csr_full;
    logic [11:0] csr_addr_m;
    logic        pend_valid;
    logic [2:0]  pend_id;
    logic [31:0] pend_result;
    logic        last_mult;
    int          errors;
    int          cycles;

    always #20 clk = ~clk;

    ex_stage DUT (
        .clk_i                 ( clk            ),
        .rst_ni                ( rst_n          ),
        .flush_i               ( cur.flush      ),
        .fu_data_i             ( cur.data       ),
        .pc_i                  ( cur.pc         ),
        .is_compressed_instr_i ( cur.compressed ),
        .alu_valid_i           ( cur.alu        ),
        .branch_valid_i        ( cur.branch     ),
        .csr_valid_i           ( cur.csr        ),
        .mult_valid_i          ( cur.mult       ),
        .branch_predict_i      ( cur.pred       ),
        .csr_commit_i          ( cur.commit     ),
        .flu_wb_o              ( flu_wb         ),
        .flu_ready_o           ( flu_ready      ),
        .resolved_branch_o     ( resolved       ),
        .csr_addr_o            ( csr_addr       )
    );

    `include "ex_model.svh"

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Operator from a contiguous range of the encoding
    function automatic ex_pkg::fu_op_e pick_op(input int unsigned base, input int unsigned span);
        logic [4:0] code;
        code = 5'(base + rand_below(span));
        return ex_pkg::fu_op_e'(code);
    endfunction

    task automatic fill_operands(input ex_pkg::fu_op_e op);
        nxt.data.operator  = op;
        nxt.data.operand_a = $random(seed);
        // Equal operands now and then so EQ and GE outcomes show up
        if (rand_below(4) == 0) begin
            nxt.data.operand_b.data = nxt.data.operand_a;
        end else begin
            nxt.data.operand_b.data = $random(seed);
        end
        nxt.data.imm      = $random(seed);
        nxt.data.trans_id = 3'($random(seed));
    endtask

    // Unit 0 ALU, 1 branch, 2 CSR, 3 multiplier
    task automatic set_unit(input int unsigned unit);
        case (unit)
            0: begin
                nxt.alu = 1'b1;
                fill_operands(pick_op(0, 10));
            end
            1: begin
                nxt.branch = 1'b1;
                fill_operands(pick_op(10, 7));
                nxt.pc         = $random(seed);
                nxt.compressed = 1'(rand_below(2));
                nxt.pred.taken = 1'(rand_below(2));
                if (rand_below(2) == 0) begin
                    nxt.pred.target = model_target(nxt.data, nxt.pc);
                end else begin
                    nxt.pred.target = $random(seed);
                end
            end
            2: begin
                nxt.csr = 1'b1;
                fill_operands(ex_pkg::CSR_RW);
            end
            default: begin
                nxt.mult = 1'b1;
                fill_operands(pick_op(18, 3));
            end
        endcase
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAILED %s: %s expected %h actual %h at %0t", test, what, exp, act, $time);
    endtask

    task automatic run_cycle(input string test);
        logic        exp_valid;
        logic [2:0]  exp_id;
        logic [31:0] exp_result;
        logic        exp_taken;
        logic [31:0] exp_target;
        logic        exp_mispredict;
        @(posedge clk);
        #2;
        cur = nxt;
        nxt = '0;
        #36;
        exp_valid  = cur.alu | cur.branch | cur.csr | pend_valid;
        exp_id     = cur.data.trans_id;
        exp_result = cur.data.operand_a;
        if (cur.alu) begin
            exp_result = model_alu(cur.data);
        end else if (cur.branch) begin
            exp_result = cur.pc + (cur.compressed ? 32'd2 : 32'd4);
        end else if (!cur.csr) begin
            exp_id     = pend_id;
            exp_result = pend_result;
        end
        exp_taken      = model_taken(cur.data);
        exp_target     = model_target(cur.data, cur.pc);
        exp_mispredict = (exp_taken != cur.pred.taken)
                       || (exp_taken && cur.pred.taken && (exp_target != cur.pred.target));

        if (flu_wb.valid !== exp_valid)
            report_mismatch(test, "wb valid", 32'(exp_valid), 32'(flu_wb.valid));
        if (exp_valid && flu_wb.result !== exp_result)
            report_mismatch(test, "wb result", exp_result, flu_wb.result);
        if (exp_valid && flu_wb.trans_id !== exp_id)
            report_mismatch(test, "wb id", 32'(exp_id), 32'(flu_wb.trans_id));
        if (resolved.valid !== cur.branch)
            report_mismatch(test, "branch valid", 32'(cur.branch), 32'(resolved.valid));
        if (cur.branch && resolved.pc !== cur.pc)
            report_mismatch(test, "branch pc", cur.pc, resolved.pc);
        if (cur.branch && resolved.is_taken !== exp_taken)
            report_mismatch(test, "taken", 32'(exp_taken), 32'(resolved.is_taken));
        if (cur.branch && resolved.target_address !== exp_target)
            report_mismatch(test, "target", exp_target, resolved.target_address);
        if (cur.branch && resolved.is_mispredict !== exp_mispredict)
            report_mismatch(test, "mispredict", 32'(exp_mispredict),
                            32'(resolved.is_mispredict));
        if (flu_ready !== !csr_full)
            report_mismatch(test, "ready", 32'(!csr_full), 32'(flu_ready));
        if (csr_full && csr_addr !== csr_addr_m)
            report_mismatch(test, "csr addr", 32'(csr_addr_m), 32'(csr_addr));

        // Advance the model to the next cycle
        if (cur.commit || cur.flush) begin
            csr_full = 1'b0;
        end else if (cur.csr) begin
            csr_full = 1'b1;
        end
        if (cur.csr) begin
            csr_addr_m = cur.data.operand_b.csr.addr;
        end
        pend_valid  = cur.mult & ~cur.flush;
        pend_id     = cur.data.trans_id;
        pend_result = model_mult(cur.data);
        last_mult   = cur.mult;
        cycles++;
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns before all phases finished", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

    // --------------------------------------------------
    // Test phases
    // --------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        cur         = '0;
        nxt         = '0;
        csr_full    = 1'b0;
        csr_addr_m  = '0;
        pend_valid  = 1'b0;
        pend_id     = '0;
        pend_result = '0;
        last_mult   = 1'b0;
        errors      = 0;
        cycles      = 0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (3) run_cycle("reset");
        repeat (N_ALU) begin
            set_unit(0);
            run_cycle("alu");
        end
        repeat (N_BRANCH) begin
            set_unit(1);
            run_cycle("branch");
        end
        // Issue, hold, then release by commit or flush
        repeat (N_CSR) begin
            set_unit(2);
            run_cycle("csr");
            repeat (rand_below(2)) run_cycle("csr");
            if (rand_below(2) == 0) begin
                nxt.commit = 1'b1;
            end else begin
                nxt.flush = 1'b1;
            end
            run_cycle("csr");
        end
        repeat (N_MULT) begin
            set_unit(3);
            nxt.flush = (rand_below(8) == 0);
            run_cycle("mult");
        end
        run_cycle("mult");
        // Mixed stream under the issue rule
        repeat (N_MIXED) begin
            case (rand_below(6))
                0, 1: begin
                    if (!last_mult) set_unit(rand_below(2));
                end
                2: begin
                    if (!last_mult && !csr_full) set_unit(2);
                end
                3, 4: set_unit(3);
                default: ;
            endcase
            nxt.commit = csr_full && (rand_below(4) == 0);
            nxt.flush  = (rand_below(16) == 0);
            run_cycle("mixed");
        end
        run_cycle("mixed");

        $display("Cycles checked: %0d, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
hdl/ex_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/csr_buffer.sv
hdl/mult.sv
hdl/flu_wb_arbiter.sv
hdl/ex_stage.sv
verif/ex_stage_tb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
LOG       ?= sim.log
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ns -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
